/* stream_config.svh */
////////////////////////////////////////////////////////////////////////////
// stream merger configuration
// sizes shared by the input FIFOs, the arbiter and the top level
////////////////////////////////////////////////////////////////////////////

`ifndef STREAM_CONFIG_SVH
`define STREAM_CONFIG_SVH

// width of one data word on every stream
`define STREAM_DATA_WIDTH 32

// number of input ports feeding the merged stream
// keep in step with the port index width in the package
`define STREAM_NUM_PORTS 4

// words held by each input FIFO
// power of two only, the pointers wrap naturally
`define STREAM_FIFO_DEPTH 8

`endif

////////////////////////////////////////////////////////////////////////////
////////////////////////////////////////////////////////////////////////////

/* stream_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// stream merger types
// beat layout of the merged output, source port index and the
// arbiter state encoding
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "stream_config.svh"

package stream_pkg;

  //////////////////////////////////////////////////////////////////////////
  // port index
  //////////////////////////////////////////////////////////////////////////

  // wide enough to name every input port
  typedef logic [$clog2(`STREAM_NUM_PORTS)-1:0] port_idx_t;

  //////////////////////////////////////////////////////////////////////////
  // output beat
  //////////////////////////////////////////////////////////////////////////

  // one word on the merged stream
  // src sits in the upper bits, data below it
  typedef struct packed {
    port_idx_t                     src;
    logic [`STREAM_DATA_WIDTH-1:0] data;
  } beat_t;

  //////////////////////////////////////////////////////////////////////////
  // arbiter state
  //////////////////////////////////////////////////////////////////////////

  // idle means the output register is empty
  // hold means it carries a beat not yet taken downstream
  typedef enum logic {
    arb_idle = 1'b0,
    arb_hold = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

/* axis_fifo_sync.sv */
////////////////////////////////////////////////////////////////////////////
// synchronous stream FIFO
// valid/ready on both sides, first word falls through to the read port
// register memory with extended pointers for full/empty detection
//
// reset   : synchronous, active high
// output  : unregistered head word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "stream_config.svh"

module axis_fifo_sync #(

  // number of words, power of two
  parameter int DEPTH = `STREAM_FIFO_DEPTH

) (

  // core interface
  input  logic                          clk,
  input  logic                          reset,

  // slave interface
  input  logic                          s_valid,
  output logic                          s_ready,
  input  logic [`STREAM_DATA_WIDTH-1:0] s_data,

  // master interface
  output logic                          m_valid,
  input  logic                          m_ready,
  output logic [`STREAM_DATA_WIDTH-1:0] m_data

);

  //////////////////////////////////////////////////////////////////////////
  // local sizes
  //////////////////////////////////////////////////////////////////////////

  // address bits into the memory
  localparam int AW = $clog2(DEPTH);

  // pointer step, one bit wider than the address
  localparam logic [AW:0] PTR_ONE = {{AW{1'b0}}, 1'b1};

  //////////////////////////////////////////////////////////////////////////
  // internal signals
  //////////////////////////////////////////////////////////////////////////

  // storage, no reset on payload
  logic [`STREAM_DATA_WIDTH-1:0] mem [DEPTH];

  // pointers carry a wrap bit above the address
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;

  logic        fifo_full;
  logic        fifo_empty;
  logic        fifo_write;
  logic        fifo_read;

  //////////////////////////////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////////////////////////////

  // same address, wrap bits differ
  assign fifo_full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                      (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  // pointers equal including wrap bit
  assign fifo_empty = (wr_ptr_q == rd_ptr_q);

  // slave side
  assign s_ready    = ~fifo_full;
  assign fifo_write = s_valid & s_ready;

  // master side
  assign m_valid    = ~fifo_empty;
  assign fifo_read  = m_valid & m_ready;

  //////////////////////////////////////////////////////////////////////////
  // pointers
  //////////////////////////////////////////////////////////////////////////

  // write side
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
    end else if (fifo_write) begin
      wr_ptr_q <= wr_ptr_q + PTR_ONE;
    end
  end

  // read side, independent of write so both may move in one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr_q <= '0;
    end else if (fifo_read) begin
      rd_ptr_q <= rd_ptr_q + PTR_ONE;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fifo_write) begin
      mem[wr_ptr_q[AW-1:0]] <= s_data;
    end
  end

  // head word straight out of the array
  // visible the cycle after it was written into an empty FIFO
  assign m_data = mem[rd_ptr_q[AW-1:0]];

endmodule

`default_nettype wire

/* axis_rr_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// round-robin stream arbiter
// picks one valid FIFO head per cycle, starting after the last winner,
// and registers the beat with its source port on the merged stream
//
// reset   : synchronous, active high
// output  : registered
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "stream_config.svh"

module axis_rr_arbiter (

  // core interface
  input  logic                                                clk,
  input  logic                                                reset,

  // FIFO heads
  input  logic [`STREAM_NUM_PORTS-1:0]                        fifo_valid,
  input  logic [`STREAM_NUM_PORTS-1:0][`STREAM_DATA_WIDTH-1:0] fifo_data,
  output logic [`STREAM_NUM_PORTS-1:0]                        fifo_ready,

  // merged stream
  output logic                                                out_valid,
  input  logic                                                out_ready,
  output stream_pkg::beat_t                                   out_beat

);

  localparam int NP = `STREAM_NUM_PORTS;

  //////////////////////////////////////////////////////////////////////////
  // internal signals
  //////////////////////////////////////////////////////////////////////////

  // control state
  stream_pkg::arb_state_e state_q;
  stream_pkg::port_idx_t  prio_q;

  // output register payload
  stream_pkg::beat_t      beat_q;

  // search results
  stream_pkg::port_idx_t  cand_idx;
  stream_pkg::port_idx_t  grant_idx;
  logic                   found;
  logic                   can_take;
  logic                   take;

  //////////////////////////////////////////////////////////////////////////
  // round-robin search
  //////////////////////////////////////////////////////////////////////////

  // walk the ports from prio_q upward with wrap
  // first valid one wins
  always_comb begin
    found     = 1'b0;
    grant_idx = prio_q;
    cand_idx  = prio_q;
    for (int i = 0; i < NP; i++) begin
      cand_idx = stream_pkg::port_idx_t'((int'(prio_q) + i) % NP);
      if (!found && fifo_valid[cand_idx]) begin
        found     = 1'b1;
        grant_idx = cand_idx;
      end
    end
  end

  // register free now or drained this cycle
  assign can_take = (state_q == stream_pkg::arb_idle) || out_ready;
  assign take     = found && can_take;

  // one-hot ready, only toward the winner
  always_comb begin
    fifo_ready = '0;
    if (take) begin
      fifo_ready[grant_idx] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= stream_pkg::arb_idle;
      prio_q  <= '0;
    end else begin
      if (take) begin
        state_q <= stream_pkg::arb_hold;
        // next search starts just past the winner
        prio_q  <= stream_pkg::port_idx_t'((int'(grant_idx) + 1) % NP);
      end else if (out_ready) begin
        state_q <= stream_pkg::arb_idle;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////

  // loaded only on a take, so it stays put under back-pressure
  always_ff @(posedge clk) begin
    if (take) begin
      beat_q.src  <= grant_idx;
      beat_q.data <= fifo_data[grant_idx];
    end
  end

  assign out_valid = (state_q == stream_pkg::arb_hold);
  assign out_beat  = beat_q;

endmodule

`default_nettype wire

/* axis_merge_top.sv */
////////////////////////////////////////////////////////////////////////////
// four-port stream merger
// one FIFO per input stream, a round-robin arbiter shares the single
// output stream among them and tags each beat with its source port
//
// latency : 2 cycles without contention
// reset   : synchronous, active high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "stream_config.svh"

module axis_merge_top (

  // core interface
  input  logic                                                clk,
  input  logic                                                reset,

  // input streams, one bit or word per port
  input  logic [`STREAM_NUM_PORTS-1:0]                        in_valid,
  output logic [`STREAM_NUM_PORTS-1:0]                        in_ready,
  input  logic [`STREAM_NUM_PORTS-1:0][`STREAM_DATA_WIDTH-1:0] in_data,

  // merged output stream
  output logic                                                out_valid,
  input  logic                                                out_ready,
  output stream_pkg::beat_t                                   out_beat

);

  //////////////////////////////////////////////////////////////////////////
  // FIFO to arbiter wiring
  //////////////////////////////////////////////////////////////////////////

  logic [`STREAM_NUM_PORTS-1:0]                         fifo_valid;
  logic [`STREAM_NUM_PORTS-1:0]                         fifo_ready;
  logic [`STREAM_NUM_PORTS-1:0][`STREAM_DATA_WIDTH-1:0] fifo_data;

  // one FIFO per port
  // instances land at gen_fifo[0..3].u_fifo
  for (genvar i = 0; i < `STREAM_NUM_PORTS; i++) begin : gen_fifo
    axis_fifo_sync #(
      .DEPTH   (`STREAM_FIFO_DEPTH)
    ) u_fifo (
      .clk     (clk),
      .reset   (reset),
      .s_valid (in_valid[i]),
      .s_ready (in_ready[i]),
      .s_data  (in_data[i]),
      .m_valid (fifo_valid[i]),
      .m_ready (fifo_ready[i]),
      .m_data  (fifo_data[i])
    );
  end

  //////////////////////////////////////////////////////////////////////////
  // arbiter and output register
  //////////////////////////////////////////////////////////////////////////

  axis_rr_arbiter u_arb (
    .clk        (clk),
    .reset      (reset),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_ready (fifo_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

`default_nettype wire

/* tb_axis_merge.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the four-port stream merger
// xorshift traffic into all ports, per-port scoreboard queues,
// concurrent assertions on order, stability, fairness and latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "stream_config.svh"

module tb_axis_merge;

  localparam int NP              = `STREAM_NUM_PORTS;
  localparam int DEPTH           = `STREAM_FIFO_DEPTH;
  localparam int RAND_BEATS      = 40;
  localparam int FAIR_BEATS      = 24;
  localparam int LAT_PORT        = 2;
  localparam int DRAIN_LIMIT     = 200;
  localparam int TOTAL_BEATS     = NP * (RAND_BEATS + FAIR_BEATS) + DEPTH + 3;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 500;

  logic                                                 clk;
  logic                                                 reset;
  logic [NP-1:0]                                        in_valid;
  logic [NP-1:0]                                        in_ready;
  logic [NP-1:0][`STREAM_DATA_WIDTH-1:0]                in_data;
  logic                                                 out_valid;
  logic                                                 out_ready;
  stream_pkg::beat_t                                    out_beat;

  // stimulus and bookkeeping
  logic [31:0]                   rng_state;
  int                            seq_cnt [NP];
  logic [`STREAM_DATA_WIDTH-1:0] sb_q [NP][$];
  int                            err_cnt;
  int                            err_mark;
  int                            pass_cnt;
  int                            fail_cnt;
  int                            cap_cnt;
  bit                            head_ok_q;
  bit                            rot_ok_q;
  bit                            fair_armed_q;
  stream_pkg::port_idx_t         last_src_q;

  // test phase flags, changed on falling edges only
  bit lat_mode;
  bit fair_mode;
  bit cap_mode;

  axis_merge_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // port in the top bits, sequence number in the low half
  function automatic logic [31:0] make_word(input int port);
    logic [31:0] rnd;
    logic [31:0] word;
    rnd  = next_rand();
    word = {port[1:0], 6'd0, rnd[7:0], seq_cnt[port][15:0]};
    seq_cnt[port] = seq_cnt[port] + 1;
    return word;
  endfunction

  function automatic bit sb_empty();
    bit empty;
    empty = 1'b1;
    for (int p = 0; p < NP; p++) begin
      if (sb_q[p].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////////////////////////////////////////

  // falling edge sees the handshakes of the coming rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (out_valid && out_ready) begin
        if (sb_q[out_beat.src].size() > 0) begin
          head_ok_q = (sb_q[out_beat.src][0] == out_beat.data);
          void'(sb_q[out_beat.src].pop_front());
        end else begin
          head_ok_q = 1'b0;
        end
        // winner must be the port right after the previous one
        rot_ok_q     = !fair_armed_q ||
                       (out_beat.src == stream_pkg::port_idx_t'(last_src_q + 2'd1));
        last_src_q   = out_beat.src;
        fair_armed_q = fair_mode;
      end
      if (!fair_mode) begin
        fair_armed_q = 1'b0;
      end
      for (int p = 0; p < NP; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          sb_q[p].push_back(in_data[p]);
        end
      end
    end
  end

  // beats taken by port 0 during the capacity test
  always @(posedge clk) begin
    if (reset || !cap_mode) begin
      cap_cnt <= 0;
    end else if (in_valid[0] && in_ready[0]) begin
      cap_cnt <= cap_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk) $fell(reset) |-> !out_valid && (&in_ready))
    else begin
      $display("CHECK FAILED at %0t: outputs wrong right after reset", $time);
      err_cnt++;
    end

  a_src_field: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_beat.src == out_beat.data[31:30])
    else begin
      $display("CHECK FAILED at %0t: source field %0d does not match data", $time,
               out_beat.src);
      err_cnt++;
    end

  a_order: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_ready |-> head_ok_q)
    else begin
      $display("CHECK FAILED at %0t: beat %h is not the head of port %0d", $time,
               out_beat.data, out_beat.src);
      err_cnt++;
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      $display("CHECK FAILED at %0t: output changed under back-pressure", $time);
      err_cnt++;
    end

  a_rotation: assert property (@(posedge clk) disable iff (reset)
    fair_mode && out_valid && out_ready |-> rot_ok_q)
    else begin
      $display("CHECK FAILED at %0t: port %0d won out of rotation", $time,
               out_beat.src);
      err_cnt++;
    end

  a_cap_limit: assert property (@(posedge clk) disable iff (reset)
    cap_mode && !out_ready |-> cap_cnt <= DEPTH + 1)
    else begin
      $display("CHECK FAILED at %0t: port 0 took %0d beats", $time, cap_cnt);
      err_cnt++;
    end

  a_cap_full: assert property (@(posedge clk) disable iff (reset)
    cap_mode && !out_ready && cap_cnt == DEPTH + 1 |-> !in_ready[0])
    else begin
      $display("CHECK FAILED at %0t: in_ready[0] high with FIFO full", $time);
      err_cnt++;
    end

  // a lone beat is still in its FIFO one edge later, on the output after two
  a_lat_early: assert property (@(posedge clk) disable iff (reset)
    lat_mode && $past(in_valid[LAT_PORT] && in_ready[LAT_PORT], 1) |-> !out_valid)
    else begin
      $display("CHECK FAILED at %0t: beat arrived after one cycle", $time);
      err_cnt++;
    end

  a_lat_due: assert property (@(posedge clk) disable iff (reset)
    lat_mode && $past(in_valid[LAT_PORT] && in_ready[LAT_PORT], 2) |->
    out_valid && out_beat.src == stream_pkg::port_idx_t'(LAT_PORT))
    else begin
      $display("CHECK FAILED at %0t: beat missing two cycles after input", $time);
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // n_beats per enabled port, valid and ready as percentages
  task automatic run_traffic(input int n_beats, input logic [NP-1:0] ports,
                             input int valid_pct, input int ready_pct);
    int            issued [NP];
    logic [NP-1:0] vld;
    logic [NP-1:0] acc;
    bit            pending;
    for (int p = 0; p < NP; p++) begin
      issued[p] = 0;
    end
    forever begin
      @(negedge clk);
      vld     = in_valid;
      acc     = in_valid & in_ready;
      pending = 1'b0;
      for (int p = 0; p < NP; p++) begin
        if ((vld[p] && !acc[p]) || (ports[p] && issued[p] < n_beats)) begin
          pending = 1'b1;
        end
      end
      @(posedge clk);
      if (!pending) begin
        in_valid <= '0;
        break;
      end
      out_ready <= (next_rand() % 100) < ready_pct;
      // a held beat keeps valid and data until taken
      for (int p = 0; p < NP; p++) begin
        if (!vld[p] || acc[p]) begin
          if (ports[p] && issued[p] < n_beats && (next_rand() % 100) < valid_pct) begin
            in_valid[p] <= 1'b1;
            in_data[p]  <= make_word(p);
            issued[p]++;
          end else begin
            in_valid[p] <= 1'b0;
          end
        end
      end
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    @(posedge clk);
    in_valid  <= '0;
    out_ready <= 1'b1;
    while ((out_valid || !sb_empty()) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    assert (sb_empty() && !out_valid) else begin
      $display("CHECK FAILED at %0t: beats still undelivered after drain", $time);
      err_cnt++;
    end
  endtask

  // port 0 alone against a stalled output
  task automatic fill_port0();
    logic acc;
    int   low_cycles;
    int   waited;
    low_cycles = 0;
    waited     = 0;
    @(posedge clk);
    out_ready   <= 1'b0;
    in_valid[0] <= 1'b1;
    in_data[0]  <= make_word(0);
    while (low_cycles < 4 && waited < 3 * DEPTH) begin
      @(negedge clk);
      acc        = in_valid[0] && in_ready[0];
      low_cycles = in_ready[0] ? 0 : low_cycles + 1;
      waited++;
      @(posedge clk);
      if (acc) begin
        in_data[0] <= make_word(0);
      end
    end
    assert (cap_cnt == DEPTH + 1) else begin
      $display("CHECK FAILED at %0t: port 0 took %0d beats, not %0d", $time, cap_cnt,
               DEPTH + 1);
      err_cnt++;
    end
    // release the output, the pending word must then get in
    out_ready <= 1'b1;
    acc    = 1'b0;
    waited = 0;
    while (!acc && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      acc = in_ready[0];
      waited++;
      @(posedge clk);
    end
    in_valid[0] <= 1'b0;
  endtask

  task automatic start_test();
    @(negedge clk);
    err_mark = err_cnt;
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    lat_mode  = 1'b0;
    fair_mode = 1'b0;
    cap_mode  = 1'b0;
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail with %0d errors", name, err_cnt - err_mark);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rng_state    = 32'h78e7_9297;
    reset        = 1'b1;
    in_valid     = '0;
    in_data      = '0;
    out_ready    = 1'b0;
    err_cnt      = 0;
    err_mark     = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    head_ok_q    = 1'b1;
    rot_ok_q     = 1'b1;
    fair_armed_q = 1'b0;
    last_src_q   = '0;
    lat_mode     = 1'b0;
    fair_mode    = 1'b0;
    cap_mode     = 1'b0;
    for (int p = 0; p < NP; p++) begin
      seq_cnt[p] = 0;
    end

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    start_test();
    @(posedge clk);
    finish_test("reset state");

    start_test();
    lat_mode = 1'b1;
    run_traffic(1, NP'(1 << LAT_PORT), 100, 100);
    drain_outputs();
    finish_test("latency");

    start_test();
    run_traffic(RAND_BEATS, '1, 60, 70);
    drain_outputs();
    finish_test("random order");

    start_test();
    fair_mode = 1'b1;
    run_traffic(FAIR_BEATS, '1, 100, 100);
    drain_outputs();
    finish_test("fairness");

    start_test();
    cap_mode = 1'b1;
    fill_port0();
    drain_outputs();
    finish_test("capacity");

    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // bound derived from the beat count of all tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
stream_pkg.sv
axis_fifo_sync.sv
axis_rr_arbiter.sv
axis_merge_top.sv
tb_axis_merge.sv

/* Makefile */
# Verilator build and run of the stream merger testbench

TOP = tb_axis_merge
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# pass only when the simulation prints the pass line
test:
	verilator --binary --timing --assert -Wno-fatal \
	  -f flist.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ)
